//--- design/McbPkg.sv
// Microcontroller block shared definitions
// Bus widths, CSR register map and bus word types for the USI and UFI sides

`default_nettype none

package McbPkg;

	//----------------------------------------------------------------------
	// Bus widths
	//----------------------------------------------------------------------
	localparam int UsiWidth      = 32;
	localparam int UfiDqWidth    = 16;
	localparam int UfiAdrsWidth  = 32;
	// 31-bit address next to 16-bit data, one spare bit on top
	localparam int McmEntryWidth = 48;

	//----------------------------------------------------------------------
	// Bus word types
	//----------------------------------------------------------------------
	typedef logic [UsiWidth-1:0]      usiWordT;
	typedef logic [UfiDqWidth-1:0]    ufiDataT;
	typedef logic [UfiAdrsWidth-1:0]  ufiAdrsT;
	typedef logic [McmEntryWidth-1:0] mcmEntryT;

	//----------------------------------------------------------------------
	// CSR register map
	//----------------------------------------------------------------------
	typedef enum logic [7:0]
	{
		CsrRamWd   = 8'd0,
		CsrRamAdrs = 8'd1,
		CsrRamEn   = 8'd2,
		CsrStatus  = 8'd3,
		CsrUfiRd   = 8'd4,
		CsrRdCount = 8'd5
	} csrAdrsE;

	// Flag bit in the USI address word
	localparam int UsiWriteBit = 31;

	// UFI address fields
	localparam int UfiValidBit = 31;
	// Block map occupies bits 28 to 25
	localparam int UfiMapLsb   = 25;

endpackage

`default_nettype wire

//--- design/SyncFifoController.sv
// Synchronous FIFO for cache entries
// Pointers carry a wrap bit for full and empty, read data is registered

`timescale 1ns/1ns
`default_nettype none

module SyncFifoController #(
	parameter int pFifoDepth = 8
)(
	input  wire logic              iSCLK,
	input  wire logic              iSRST,
	// Write side
	input  wire McbPkg::mcmEntryT  iWd,
	input  wire logic              iWe,
	output logic                   oFull,
	// Read side
	input  wire logic              iRe,
	output McbPkg::mcmEntryT       oRd,
	output logic                   oRvd,
	output logic                   oEmp
);

localparam int AdrsWidth = $clog2(pFifoDepth);

//----------------------------------------------------------------------
// Storage and pointers
//----------------------------------------------------------------------
McbPkg::mcmEntryT        mem [pFifoDepth];
logic [AdrsWidth:0]      wrPtr;
logic [AdrsWidth:0]      rdPtr;
logic                    doWrite;
logic                    doRead;

// Same index, wrap bits differ
assign oFull = (wrPtr[AdrsWidth] != rdPtr[AdrsWidth]) &&
	(wrPtr[AdrsWidth-1:0] == rdPtr[AdrsWidth-1:0]);
assign oEmp  = (wrPtr == rdPtr);

assign doWrite = iWe & ~oFull;
assign doRead  = iRe & ~oEmp;

always_ff @(posedge iSCLK)
begin
	if (iSRST)
	begin
		wrPtr <= '0;
	end
	else if (doWrite)
	begin
		wrPtr <= wrPtr + 1'b1;
	end
end

always_ff @(posedge iSCLK)
begin
	if (doWrite)
	begin
		mem[wrPtr[AdrsWidth-1:0]] <= iWd;
	end
end

//----------------------------------------------------------------------
// Registered read
//----------------------------------------------------------------------
always_ff @(posedge iSCLK)
begin
	if (iSRST)
	begin
		rdPtr <= '0;
		oRvd  <= 1'b0;
	end
	else
	begin
		oRvd <= doRead;
		if (doRead)
		begin
			rdPtr <= rdPtr + 1'b1;
		end
	end
end

// Data holds between pops
always_ff @(posedge iSCLK)
begin
	if (doRead)
	begin
		oRd <= mem[rdPtr[AdrsWidth-1:0]];
	end
end

//----------------------------------------------------------------------
// Checks
//----------------------------------------------------------------------
aNoWriteWhenFull: assert property (
	@(posedge iSCLK) disable iff (iSRST)
	!(iWe && oFull)
) else $error("FIFO write while full");

aNoReadWhenEmpty: assert property (
	@(posedge iSCLK) disable iff (iSRST)
	!(iRe && oEmp)
) else $error("FIFO read while empty");

endmodule

`default_nettype wire

//--- design/McbUfiPort.sv
// UFI port of the microcontroller block
// One-shot cache write from the CSR enable, drain toward UFI on ready,
// and capture of UFI reads addressed to this block

`timescale 1ns/1ns
`default_nettype none

module McbUfiPort #(
	parameter logic [3:0] pUfiAdrsMap = 4'h0,
	parameter int         pFifoDepth  = 8
)(
	input  wire logic                            iSCLK,
	input  wire logic                            iSRST,
	// CSR side
	input  wire McbPkg::ufiDataT                 iRamWd,
	input  wire logic [McbPkg::UfiAdrsWidth-2:0] iRamAdrs,
	input  wire logic                            iRamEn,
	output logic                                 oRamFull,
	output logic                                 oRamEmp,
	output McbPkg::ufiDataT                      oRamRd,
	output logic                                 oRamRdVd,
	// UFI side
	input  wire logic                            iMUfiRdy,
	input  wire McbPkg::ufiDataT                 iMUfiRd,
	input  wire McbPkg::ufiAdrsT                 iMUfiAdrs,
	output McbPkg::ufiDataT                      oMUfiWd,
	output McbPkg::ufiAdrsT                      oMUfiAdrs
);

//----------------------------------------------------------------------
// Cache write one-shot
//----------------------------------------------------------------------
logic              ramEnDly;
logic              fifoWe;
logic              fifoRe;
logic              fifoFull;
logic              fifoEmp;
logic              fifoRvd;
McbPkg::mcmEntryT  fifoWd;
McbPkg::mcmEntryT  fifoRd;

always_ff @(posedge iSCLK)
begin
	if (iSRST)
	begin
		ramEnDly <= 1'b0;
	end
	else
	begin
		ramEnDly <= iRamEn;
	end
end

// Rising edge only, dropped when full
assign fifoWe = iRamEn & ~ramEnDly & ~fifoFull;
assign fifoWd = {1'b0, iRamAdrs, iRamWd};

// Pop one entry per ready cycle
assign fifoRe = iMUfiRdy & ~fifoEmp;

SyncFifoController #(
	.pFifoDepth(pFifoDepth)
) McbCacheMemory (
	.iSCLK(iSCLK),
	.iSRST(iSRST),
	.iWd(fifoWd),
	.iWe(fifoWe),
	.oFull(fifoFull),
	.iRe(fifoRe),
	.oRd(fifoRd),
	.oRvd(fifoRvd),
	.oEmp(fifoEmp)
);

assign oRamFull = fifoFull;
assign oRamEmp  = fifoEmp;

// Valid bit rides on address bit 31
assign oMUfiWd   = fifoRd[McbPkg::UfiDqWidth-1:0];
assign oMUfiAdrs = {fifoRvd, fifoRd[McbPkg::McmEntryWidth-2:McbPkg::UfiDqWidth]};

//----------------------------------------------------------------------
// UFI read capture
//----------------------------------------------------------------------
logic              ufiRdHit;
McbPkg::ufiDataT   ufiRdData;
logic              ufiRdValid;

assign ufiRdHit = iMUfiAdrs[McbPkg::UfiValidBit] &&
	(iMUfiAdrs[McbPkg::UfiMapLsb+3:McbPkg::UfiMapLsb] == pUfiAdrsMap);

always_ff @(posedge iSCLK)
begin
	if (ufiRdHit)
	begin
		ufiRdData <= iMUfiRd;
	end
end

// One-cycle pulse after the matching beat
always_ff @(posedge iSCLK)
begin
	if (iSRST)
	begin
		ufiRdValid <= 1'b0;
	end
	else
	begin
		ufiRdValid <= ufiRdHit;
	end
end

assign oRamRd   = ufiRdData;
assign oRamRdVd = ufiRdValid;

//----------------------------------------------------------------------
// Checks
//----------------------------------------------------------------------
// Back-to-back beats need ready in both cycles before them
aDrainNeedsReady: assert property (
	@(posedge iSCLK) disable iff (iSRST)
	(oMUfiAdrs[McbPkg::UfiValidBit] && $past(oMUfiAdrs[McbPkg::UfiValidBit]))
		|-> ($past(iMUfiRdy) && $past(iMUfiRdy, 2))
) else $error("UFI beats without ready");

endmodule

`default_nettype wire

//--- design/MicroControllerCsr.sv
// Microcontroller block CSR
// USI register file with block decode, write strobes, latched read select
// and capture of UFI read data with a wrapping capture counter

`timescale 1ns/1ns
`default_nettype none

module MicroControllerCsr #(
	parameter logic [7:0] pAdrsMap = 8'h01
)(
	input  wire logic                                    iSCLK,
	input  wire logic                                    iSRST,
	// USI slave
	input  wire McbPkg::usiWordT                         iSUsiWd,
	input  wire McbPkg::usiWordT                         iSUsiAdrs,
	output McbPkg::usiWordT                              oSUsiRd,
	// Cache side
	input  wire logic                                    iRamFull,
	input  wire logic                                    iRamEmp,
	input  wire McbPkg::ufiDataT                         iRamRd,
	input  wire logic                                    iRamRdVd,
	output McbPkg::ufiDataT                              oRamWd,
	output logic [McbPkg::UfiAdrsWidth-2:0]              oRamAdrs,
	output logic                                         oRamEn
);

//----------------------------------------------------------------------
// USI decode
//----------------------------------------------------------------------
logic             blockHit;
logic             usiWrite;
logic             usiReadSel;
McbPkg::csrAdrsE  usiIndex;

assign blockHit   = (iSUsiAdrs[15:8] == pAdrsMap);
assign usiWrite   = blockHit &  iSUsiAdrs[McbPkg::UsiWriteBit];
assign usiReadSel = blockHit & ~iSUsiAdrs[McbPkg::UsiWriteBit];
assign usiIndex   = McbPkg::csrAdrsE'(iSUsiAdrs[7:0]);

//----------------------------------------------------------------------
// Writable registers
//----------------------------------------------------------------------
McbPkg::ufiDataT                    ramWd;
logic [McbPkg::UfiAdrsWidth-2:0]    ramAdrs;
logic                               ramEn;

always_ff @(posedge iSCLK)
begin
	if (iSRST)
	begin
		ramWd   <= '0;
		ramAdrs <= '0;
		ramEn   <= 1'b0;
	end
	else if (usiWrite)
	begin
		case (usiIndex)
			McbPkg::CsrRamWd:   ramWd   <= iSUsiWd[McbPkg::UfiDqWidth-1:0];
			McbPkg::CsrRamAdrs: ramAdrs <= iSUsiWd[McbPkg::UfiAdrsWidth-2:0];
			McbPkg::CsrRamEn:   ramEn   <= iSUsiWd[0];
			// Status, capture and unknown indices are not writable
			default:            ;
		endcase
	end
end

assign oRamWd   = ramWd;
assign oRamAdrs = ramAdrs;
assign oRamEn   = ramEn;

//----------------------------------------------------------------------
// UFI read capture
//----------------------------------------------------------------------
McbPkg::ufiDataT  ufiRd;
logic [7:0]       rdCount;

always_ff @(posedge iSCLK)
begin
	if (iSRST)
	begin
		ufiRd   <= '0;
		rdCount <= 8'd0;
	end
	else if (iRamRdVd)
	begin
		ufiRd   <= iRamRd;
		// Wraps after 255
		rdCount <= rdCount + 8'd1;
	end
end

//----------------------------------------------------------------------
// Read select and mux
//----------------------------------------------------------------------
McbPkg::csrAdrsE  rdSel;
McbPkg::usiWordT  rdData;

always_ff @(posedge iSCLK)
begin
	if (iSRST)
	begin
		rdSel <= McbPkg::CsrRamWd;
	end
	else if (usiReadSel)
	begin
		rdSel <= usiIndex;
	end
end

always_comb
begin
	case (rdSel)
		McbPkg::CsrRamWd:   rdData = {16'd0, ramWd};
		McbPkg::CsrRamAdrs: rdData = {1'b0, ramAdrs};
		McbPkg::CsrRamEn:   rdData = {31'd0, ramEn};
		McbPkg::CsrStatus:  rdData = {30'd0, iRamFull, iRamEmp};
		McbPkg::CsrUfiRd:   rdData = {16'd0, ufiRd};
		McbPkg::CsrRdCount: rdData = {24'd0, rdCount};
		default:            rdData = '0;
	endcase
end

assign oSUsiRd = rdData;

//----------------------------------------------------------------------
// Checks
//----------------------------------------------------------------------
// Cache flags come from the port, they must stay exclusive
aFullEmpExclusive: assert property (
	@(posedge iSCLK) disable iff (iSRST)
	!(iRamFull && iRamEmp)
) else $error("cache reports full and empty together");

endmodule

`default_nettype wire

//--- design/MicroControllerBlock.sv
// Microcontroller block top level
// Connects the USI register file to the UFI cache port

`timescale 1ns/1ns
`default_nettype none

module MicroControllerBlock #(
	parameter logic [7:0] pAdrsMap    = 8'h01,
	parameter logic [3:0] pUfiAdrsMap = 4'h3,
	parameter int         pFifoDepth  = 8
)(
	input  wire logic             iSCLK,
	input  wire logic             iSRST,
	// USI slave
	input  wire McbPkg::usiWordT  iSUsiWd,
	input  wire McbPkg::usiWordT  iSUsiAdrs,
	output McbPkg::usiWordT       oSUsiRd,
	// UFI master
	input  wire logic             iMUfiRdy,
	input  wire McbPkg::ufiDataT  iMUfiRd,
	input  wire McbPkg::ufiAdrsT  iMUfiAdrs,
	output McbPkg::ufiDataT       oMUfiWd,
	output McbPkg::ufiAdrsT       oMUfiAdrs
);

//----------------------------------------------------------------------
// CSR to port wiring
//----------------------------------------------------------------------
McbPkg::ufiDataT                  ramWd;
logic [McbPkg::UfiAdrsWidth-2:0]  ramAdrs;
logic                             ramEn;
logic                             ramFull;
logic                             ramEmp;
McbPkg::ufiDataT                  ufiRdData;
logic                             ufiRdValid;

MicroControllerCsr #(
	.pAdrsMap(pAdrsMap)
) Csr (
	.iSCLK(iSCLK),
	.iSRST(iSRST),
	.iSUsiWd(iSUsiWd),
	.iSUsiAdrs(iSUsiAdrs),
	.oSUsiRd(oSUsiRd),
	.iRamFull(ramFull),
	.iRamEmp(ramEmp),
	.iRamRd(ufiRdData),
	.iRamRdVd(ufiRdValid),
	.oRamWd(ramWd),
	.oRamAdrs(ramAdrs),
	.oRamEn(ramEn)
);

McbUfiPort #(
	.pUfiAdrsMap(pUfiAdrsMap),
	.pFifoDepth(pFifoDepth)
) UfiPort (
	.iSCLK(iSCLK),
	.iSRST(iSRST),
	.iRamWd(ramWd),
	.iRamAdrs(ramAdrs),
	.iRamEn(ramEn),
	.oRamFull(ramFull),
	.oRamEmp(ramEmp),
	.oRamRd(ufiRdData),
	.oRamRdVd(ufiRdValid),
	.iMUfiRdy(iMUfiRdy),
	.iMUfiRd(iMUfiRd),
	.iMUfiAdrs(iMUfiAdrs),
	.oMUfiWd(oMUfiWd),
	.oMUfiAdrs(oMUfiAdrs)
);

endmodule

`default_nettype wire

//--- verification/McbTb.sv
// Testbench for the microcontroller block
// Runs a table of register, UFI read and drain steps whose expected values
// come from a reference model of the CSR and cache rules

`timescale 1ns/1ns
`default_nettype none

module McbTb;

localparam logic [7:0] BlockId   = 8'h01;
localparam logic [3:0] UfiMap    = 4'h3;
localparam int         FifoDepth = 8;
localparam int         MaxSteps  = 160;
// Block field 0 never matches this block
localparam logic [31:0] IdleAdrs = 32'h0000_0000;

typedef enum logic [1:0] {OpWrite, OpRead, OpUfiRead, OpDrain} stepOpE;

logic             iSCLK;
logic             iSRST;
McbPkg::usiWordT  iSUsiWd;
McbPkg::usiWordT  iSUsiAdrs;
McbPkg::usiWordT  oSUsiRd;
logic             iMUfiRdy;
McbPkg::ufiDataT  iMUfiRd;
McbPkg::ufiAdrsT  iMUfiAdrs;
McbPkg::ufiDataT  oMUfiWd;
McbPkg::ufiAdrsT  oMUfiAdrs;

MicroControllerBlock #(
	.pAdrsMap(BlockId),
	.pUfiAdrsMap(UfiMap),
	.pFifoDepth(FifoDepth)
) uut (
	.iSCLK(iSCLK),
	.iSRST(iSRST),
	.iSUsiWd(iSUsiWd),
	.iSUsiAdrs(iSUsiAdrs),
	.oSUsiRd(oSUsiRd),
	.iMUfiRdy(iMUfiRdy),
	.iMUfiRd(iMUfiRd),
	.iMUfiAdrs(iMUfiAdrs),
	.oMUfiWd(oMUfiWd),
	.oMUfiAdrs(oMUfiAdrs)
);

//----------------------------------------------------------------------
// Step table and reference model
//----------------------------------------------------------------------
stepOpE           stepOp   [MaxSteps];
McbPkg::usiWordT  stepAdrs [MaxSteps];
McbPkg::usiWordT  stepData [MaxSteps];
logic             stepRdy  [MaxSteps];
McbPkg::usiWordT  stepExp  [MaxSteps];
int               stepCount = 0;
logic             tableDone = 1'b0;

McbPkg::ufiDataT  mWd;
logic [30:0]      mAdrs;
logic             mEn;
McbPkg::ufiDataT  mUfiRd;
logic [7:0]       mRdCount;
McbPkg::ufiDataT  qWd [$];
logic [30:0]      qAdrs [$];
logic [31:0]      lcgState;

function automatic McbPkg::usiWordT nextRand();
	lcgState = lcgState * 32'd1664525 + 32'd1013904223;
	return lcgState;
endfunction

task automatic pushStep(input stepOpE op, input McbPkg::usiWordT adrs,
	input McbPkg::usiWordT data, input logic rdy, input McbPkg::usiWordT exp);
	stepOp[stepCount]   = op;
	stepAdrs[stepCount] = adrs;
	stepData[stepCount] = data;
	stepRdy[stepCount]  = rdy;
	stepExp[stepCount]  = exp;
	stepCount++;
endtask

function automatic McbPkg::usiWordT expectedRead(input logic [7:0] idx);
	case (idx)
		McbPkg::CsrRamWd:   return {16'd0, mWd};
		McbPkg::CsrRamAdrs: return {1'b0, mAdrs};
		McbPkg::CsrRamEn:   return {31'd0, mEn};
		McbPkg::CsrStatus:  return {30'd0, qWd.size() == FifoDepth, qWd.size() == 0};
		McbPkg::CsrUfiRd:   return {16'd0, mUfiRd};
		McbPkg::CsrRdCount: return {24'd0, mRdCount};
		default:            return '0;
	endcase
endfunction

task automatic addWrite(input logic [7:0] block, input logic [7:0] idx,
	input McbPkg::usiWordT data);
	pushStep(OpWrite, {1'b1, 15'd0, block, idx}, data, 1'b0, '0);
	if (block == BlockId)
	begin
		case (idx)
			McbPkg::CsrRamWd:   mWd = data[15:0];
			McbPkg::CsrRamAdrs: mAdrs = data[30:0];
			McbPkg::CsrRamEn:
			begin
				// Only a rising enable queues, and only when there is room
				if (data[0] && !mEn && qWd.size() < FifoDepth)
				begin
					qWd.push_back(mWd);
					qAdrs.push_back(mAdrs);
				end
				mEn = data[0];
			end
			default: ;
		endcase
	end
endtask

task automatic addRead(input logic [7:0] idx);
	pushStep(OpRead, {1'b0, 15'd0, BlockId, idx}, '0, 1'b0, expectedRead(idx));
endtask

task automatic addUfiRead(input McbPkg::ufiAdrsT adrs, input McbPkg::usiWordT data);
	pushStep(OpUfiRead, adrs, data, 1'b0, '0);
	if (adrs[McbPkg::UfiValidBit] && adrs[28:25] == UfiMap)
	begin
		mUfiRd   = data[15:0];
		mRdCount = mRdCount + 8'd1;
	end
endtask

task automatic addDrain();
	pushStep(OpDrain, {1'b1, qAdrs.pop_front()}, '0, 1'b1, {16'd0, qWd.pop_front()});
endtask

// Ready high with nothing expected on the bus
task automatic addDrainIdle();
	pushStep(OpDrain, '0, '0, 1'b1, '0);
endtask

task automatic queueEntry(input McbPkg::usiWordT wd, input McbPkg::usiWordT adrs);
	addWrite(BlockId, McbPkg::CsrRamWd, wd);
	addWrite(BlockId, McbPkg::CsrRamAdrs, adrs);
	addWrite(BlockId, McbPkg::CsrRamEn, 32'd1);
	addWrite(BlockId, McbPkg::CsrRamEn, 32'd0);
endtask

task automatic buildTable();
	McbPkg::usiWordT adrsRand;
	lcgState = 32'd48;
	mWd      = '0;
	mAdrs    = '0;
	mEn      = 1'b0;
	mUfiRd   = '0;
	mRdCount = 8'd0;
	// State right after reset
	addRead(McbPkg::CsrRamWd);
	addRead(McbPkg::CsrStatus);
	addRead(McbPkg::CsrRdCount);
	addDrainIdle();
	// Register readback, foreign block id, read-only status
	addWrite(BlockId, McbPkg::CsrRamWd, nextRand());
	addRead(McbPkg::CsrRamWd);
	addWrite(BlockId, McbPkg::CsrRamAdrs, nextRand());
	addRead(McbPkg::CsrRamAdrs);
	addWrite(BlockId, McbPkg::CsrRamEn, nextRand() | 32'd1);
	addRead(McbPkg::CsrRamEn);
	addWrite(BlockId, McbPkg::CsrRamEn, nextRand() & ~32'd1);
	addRead(McbPkg::CsrRamEn);
	addWrite(8'h02, McbPkg::CsrRamWd, nextRand());
	addWrite(8'h02, McbPkg::CsrRamAdrs, nextRand());
	addRead(McbPkg::CsrRamWd);
	addRead(McbPkg::CsrRamAdrs);
	addWrite(BlockId, McbPkg::CsrStatus, 32'hFFFF_FFFF);
	addRead(McbPkg::CsrStatus);
	addRead(8'h07);
	// The enable pulse above left one entry behind
	addDrain();
	addDrainIdle();
	// Three entries held back, then drained in order
	repeat (3)
		queueEntry(nextRand(), nextRand());
	addRead(McbPkg::CsrStatus);
	repeat (3)
		addDrain();
	addDrainIdle();
	addRead(McbPkg::CsrStatus);
	// Enable held high across data changes
	addWrite(BlockId, McbPkg::CsrRamWd, nextRand());
	addWrite(BlockId, McbPkg::CsrRamAdrs, nextRand());
	addWrite(BlockId, McbPkg::CsrRamEn, 32'd1);
	repeat (3)
	begin
		addWrite(BlockId, McbPkg::CsrRamWd, nextRand());
		addWrite(BlockId, McbPkg::CsrRamAdrs, nextRand());
	end
	addWrite(BlockId, McbPkg::CsrRamEn, 32'd1);
	addRead(McbPkg::CsrStatus);
	addWrite(BlockId, McbPkg::CsrRamEn, 32'd0);
	addWrite(BlockId, McbPkg::CsrRamWd, nextRand());
	addWrite(BlockId, McbPkg::CsrRamEn, 32'd1);
	addWrite(BlockId, McbPkg::CsrRamEn, 32'd0);
	repeat (2)
		addDrain();
	addDrainIdle();
	// Overfill drops the ninth entry
	repeat (9)
		queueEntry(nextRand(), nextRand());
	addRead(McbPkg::CsrStatus);
	repeat (8)
		addDrain();
	addDrainIdle();
	addRead(McbPkg::CsrStatus);
	// UFI read capture, then reads that must be ignored
	repeat (3)
	begin
		adrsRand = nextRand();
		addUfiRead({1'b1, 2'b00, UfiMap, adrsRand[24:0]}, nextRand());
	end
	addRead(McbPkg::CsrUfiRd);
	addRead(McbPkg::CsrRdCount);
	adrsRand = nextRand();
	addUfiRead({1'b1, 2'b00, 4'h5, adrsRand[24:0]}, nextRand());
	adrsRand = nextRand();
	addUfiRead({1'b0, 2'b00, UfiMap, adrsRand[24:0]}, nextRand());
	addRead(McbPkg::CsrUfiRd);
	addRead(McbPkg::CsrRdCount);
endtask

//----------------------------------------------------------------------
// Compare tasks
//----------------------------------------------------------------------
task automatic checkUsiRd(input McbPkg::usiWordT got, input McbPkg::usiWordT exp,
	input int step);
	if (got !== exp)
	begin
		$display("error at %0t ns: step %0d USI read 0x%08h, expected 0x%08h",
			$time, step, got, exp);
		$display("sim failed");
		$fatal(1, "USI readback mismatch");
	end
endtask

task automatic checkUfiEntry(input McbPkg::ufiDataT gotWd, input McbPkg::ufiAdrsT gotAdrs,
	input McbPkg::ufiDataT expWd, input McbPkg::ufiAdrsT expAdrs, input int step);
	logic bad;
	// With no beat expected only the valid bit matters
	if (expAdrs[McbPkg::UfiValidBit])
		bad = (gotWd !== expWd) || (gotAdrs !== expAdrs);
	else
		bad = (gotAdrs[McbPkg::UfiValidBit] !== 1'b0);
	if (bad)
	begin
		$display("error at %0t ns: step %0d UFI 0x%04h @ 0x%08h, expected 0x%04h @ 0x%08h",
			$time, step, gotWd, gotAdrs, expWd, expAdrs);
		$display("sim failed");
		$fatal(1, "UFI entry mismatch");
	end
endtask

//----------------------------------------------------------------------
// Clock, watchdog and step loop
//----------------------------------------------------------------------
initial
begin
	iSCLK = 1'b0;
	forever #5 iSCLK = ~iSCLK;
end

initial
begin
	wait (tableDone);
	repeat (stepCount * 40) @(posedge iSCLK);
	$display("timeout: the test steps did not finish within %0d clock cycles",
		stepCount * 40);
	$display("sim failed");
	$fatal(1, "watchdog expired");
end

initial
begin
	iSRST     = 1'b1;
	iSUsiWd   = '0;
	iSUsiAdrs = IdleAdrs;
	iMUfiRdy  = 1'b0;
	iMUfiRd   = '0;
	iMUfiAdrs = '0;
	buildTable();
	tableDone = 1'b1;
	repeat (3) @(posedge iSCLK);
	@(negedge iSCLK);
	iSRST = 1'b0;
	for (int i = 0; i < stepCount; i++)
	begin
		iSUsiAdrs = IdleAdrs;
		iSUsiWd   = '0;
		iMUfiAdrs = '0;
		iMUfiRd   = '0;
		iMUfiRdy  = stepRdy[i];
		case (stepOp[i])
			OpWrite:
			begin
				iSUsiAdrs = stepAdrs[i];
				iSUsiWd   = stepData[i];
				@(negedge iSCLK);
			end
			OpRead:
			begin
				iSUsiAdrs = stepAdrs[i];
				@(negedge iSCLK);
				checkUsiRd(oSUsiRd, stepExp[i], i);
			end
			OpUfiRead:
			begin
				iMUfiAdrs = stepAdrs[i];
				iMUfiRd   = stepData[i][15:0];
				@(negedge iSCLK);
			end
			default:
			begin
				if (stepAdrs[i][McbPkg::UfiValidBit])
				begin
					@(negedge iSCLK);
					while (!oMUfiAdrs[McbPkg::UfiValidBit])
						@(negedge iSCLK);
					checkUfiEntry(oMUfiWd, oMUfiAdrs, stepExp[i][15:0], stepAdrs[i], i);
				end
				else
				begin
					repeat (4)
					begin
						@(negedge iSCLK);
						checkUfiEntry(oMUfiWd, oMUfiAdrs, '0, stepAdrs[i], i);
					end
				end
			end
		endcase
	end
	$display("sim passed");
	$finish;
end

endmodule

`default_nettype wire

//--- project.f
design/McbPkg.sv
design/SyncFifoController.sv
design/McbUfiPort.sv
design/MicroControllerCsr.sv
design/MicroControllerBlock.sv
verification/McbTb.sv

//--- run.sh
#!/bin/sh
# Build and run the microcontroller block testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
	--top-module McbTb -f project.f -o McbSim
./obj_dir/McbSim
